// File: dv/lsu_tb.sv
// directed testbench for lsu_top; RAM bytes are only read after the test has written them, and the run stops at MAX_CYCLES
`default_nettype none

module lsu_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_PERIOD = 50;   // 100 ns clock
    localparam int DONE_LIMIT  = 8;    // cycles allowed from accept to done
    localparam int MAX_CYCLES  = 400;  // about 275 cycles of tests plus margin
    localparam int MEM_BYTES   = lsu_pkg::DMEM_WORDS * 4;  // addresses wrap at this size

    logic              clk = 1'b0;
    logic              reset;
    logic              req_valid;
    lsu_pkg::lsu_req_t req;
    logic              busy;
    logic              done;
    lsu_pkg::lsu_rsp_t rsp;

    logic [31:0] lfsr_q = 32'h997d_61ff;  // random data source
    logic [7:0]  ref_mem [MEM_BYTES];     // byte-level model of the RAM
    logic        done_timeout = 1'b0;     // a request never saw its done pulse
    int          errors = 0;
    int          checks = 0;
    int          tests_run = 0;
    int          cycles = 0;

    lsu_top u_dut (
        .clk_i       (clk),
        .reset_i     (reset),
        .req_valid_i (req_valid),
        .req_i       (req),
        .busy_o      (busy),
        .done_o      (done),
        .rsp_o       (rsp)
    );

    always #HALF_PERIOD clk = ~clk;

    // watchdog stops a run that never reaches its end
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (done_timeout || cycles >= MAX_CYCLES) begin
            if (!done_timeout) begin
                $display("run exceeded %0d cycles without finishing", MAX_CYCLES);
            end
            $display("Result: FAILED");
            $finish;
        end
    end

    // x^32 + x^22 + x^2 + x + 1, one step per bit handed out
    function automatic logic lfsr_step();
        logic fb;
        fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_step()};  // fresh bit enters at the bottom
        end
        return r;
    endfunction

    function automatic logic is_store(lsu_pkg::mem_op_e op);
        return op inside {lsu_pkg::OP_SB, lsu_pkg::OP_SH, lsu_pkg::OP_SW};
    endfunction

    // halfwords need an even address, words a multiple of four
    function automatic logic misaligned(lsu_pkg::mem_op_e op, logic [31:0] addr);
        if (op inside {lsu_pkg::OP_LH, lsu_pkg::OP_LHU, lsu_pkg::OP_SH}) return addr[0];
        if (op inside {lsu_pkg::OP_LW, lsu_pkg::OP_SW}) return addr[1:0] != 2'b00;
        return 1'b0;
    endfunction

    function automatic logic [31:0] ref_load(lsu_pkg::mem_op_e op, logic [31:0] addr);
        int i;
        i = int'(addr % MEM_BYTES);  // little endian, lowest byte at i
        case (op)
            lsu_pkg::OP_LB:  return {{24{ref_mem[i][7]}}, ref_mem[i]};
            lsu_pkg::OP_LBU: return {24'h0, ref_mem[i]};
            lsu_pkg::OP_LH:  return {{16{ref_mem[i+1][7]}}, ref_mem[i+1], ref_mem[i]};
            lsu_pkg::OP_LHU: return {16'h0, ref_mem[i+1], ref_mem[i]};
            lsu_pkg::OP_LW:  return {ref_mem[i+3], ref_mem[i+2], ref_mem[i+1], ref_mem[i]};
            default:         return 32'h0;
        endcase
    endfunction

    function automatic void ref_store(lsu_pkg::mem_op_e op, logic [31:0] addr, logic [31:0] d);
        int i;
        i = int'(addr % MEM_BYTES);
        ref_mem[i] = d[7:0];  // every store writes its lowest byte here
        if (op != lsu_pkg::OP_SB) ref_mem[i+1] = d[15:8];
        if (op == lsu_pkg::OP_SW) begin
            ref_mem[i+2] = d[23:16];
            ref_mem[i+3] = d[31:24];
        end
    endfunction

    task automatic check(string name, logic [31:0] got, logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic report_test(string name, int errors_before);
        tests_run++;
        $display("test %0d %s finished with %0d errors", tests_run, name, errors - errors_before);
    endtask

    // strobe one request on a falling edge and wait for done_o
    task automatic send_req(input lsu_pkg::lsu_req_t r, output int lat,
                            output lsu_pkg::lsu_rsp_t got);
        @(negedge clk);
        check("busy_o", 32'(busy), 32'h0);  // also proves busy fell after the last done
        req_valid = 1'b1;
        req       = r;
        @(negedge clk);
        req_valid = 1'b0;
        lat       = 0;  // the accepting rising edge is the one just behind this falling edge
        while (!done && lat < DONE_LIMIT) begin
            @(negedge clk);
            lat++;
        end
        if (!done) begin
            $display("done_o did not arrive within %0d cycles of the request", DONE_LIMIT);
            done_timeout = 1'b1;
            wait (!done_timeout);  // the watchdog ends the run at the next rising edge
        end else begin
            check("busy_o", 32'(busy), 32'h1);  // still busy while done is high
            got = rsp;
        end
    endtask

    // one access checked for fault, data and latency against the model
    task automatic access(lsu_pkg::mem_op_e op, logic [31:0] base, logic [31:0] offset,
                          logic [31:0] wdata);
        lsu_pkg::lsu_req_t r;
        lsu_pkg::lsu_rsp_t got;
        logic [31:0]       addr;
        logic              mis;
        logic [31:0]       exp_data;
        int                exp_lat;
        int                lat;
        r.op     = op;
        r.base   = base;
        r.offset = offset;
        r.wdata  = wdata;
        addr     = base + offset;
        mis      = misaligned(op, addr);
        exp_data = (mis || is_store(op)) ? 32'h0 : ref_load(op, addr);
        exp_lat  = mis ? 1 : int'(lsu_pkg::MEM_WAIT_CYCLES) + 2;
        send_req(r, lat, got);
        check("rsp_o.fault", 32'(got.fault), 32'(mis));
        check("rsp_o.rdata", got.rdata, exp_data);
        check("done_o latency", lat, exp_lat);
        if (!mis && is_store(op)) ref_store(op, addr, wdata);  // faults leave memory alone
    endtask

    task automatic word_roundtrip_test();
        int          e0;
        logic [31:0] r;
        logic [31:0] base;
        logic [31:0] off;
        e0 = errors;
        check("busy_o", 32'(busy), 32'h0);
        check("done_o", 32'(done), 32'h0);
        for (int k = 0; k < 4; k++) begin
            r    = rand_bits(30);
            base = {r[29:0], 2'b00};
            r    = rand_bits(10);
            off  = {{20{k[0]}}, r[9:0], 2'b00};  // odd rounds use a negative immediate
            access(lsu_pkg::OP_SW, base, off, rand_bits(32));
            access(lsu_pkg::OP_LW, base + off + 32'd8, 32'hffff_fff8, 32'h0);  // same word
        end
        report_test("word store and load", e0);
    endtask

    task automatic subword_store_test();
        int          e0;
        logic [31:0] r;
        logic [31:0] w;
        e0 = errors;
        r  = rand_bits(30);
        w  = {r[29:0], 2'b00};
        access(lsu_pkg::OP_SW, w, 32'h0, rand_bits(32));
        for (int off = 0; off < 4; off++) begin
            access(lsu_pkg::OP_SB, w, 32'(off), rand_bits(32));  // upper bytes must be dropped
            access(lsu_pkg::OP_LW, w, 32'h0, 32'h0);
        end
        for (int off = 0; off < 4; off += 2) begin
            access(lsu_pkg::OP_SH, w, 32'(off), rand_bits(32));
            access(lsu_pkg::OP_LW, w, 32'h0, 32'h0);
        end
        report_test("byte and halfword stores", e0);
    endtask

    task automatic extension_test();
        int          e0;
        logic [31:0] r;
        logic [31:0] w;
        e0 = errors;
        r  = rand_bits(30);
        w  = {r[29:0], 2'b00};
        access(lsu_pkg::OP_SW, w, 32'h0, rand_bits(32) | 32'h8080_8080);  // every lane negative
        for (int off = 0; off < 4; off++) begin
            access(lsu_pkg::OP_LB, w + 32'd4, 32'(off) - 32'd4, 32'h0);
            access(lsu_pkg::OP_LBU, w + 32'd4, 32'(off) - 32'd4, 32'h0);
        end
        for (int off = 0; off < 4; off += 2) begin
            access(lsu_pkg::OP_LH, w, 32'(off), 32'h0);
            access(lsu_pkg::OP_LHU, w, 32'(off), 32'h0);
        end
        report_test("load sign and zero extension", e0);
    endtask

    task automatic misaligned_test();
        int          e0;
        logic [31:0] r;
        logic [31:0] w;
        e0 = errors;
        r  = rand_bits(30);
        w  = {r[29:0], 2'b00};
        access(lsu_pkg::OP_SW, w, 32'h0, rand_bits(32));
        for (int off = 1; off < 4; off++) begin
            access(lsu_pkg::OP_LW, w, 32'(off), 32'h0);
            access(lsu_pkg::OP_SW, w, 32'(off), rand_bits(32));
        end
        for (int off = 1; off < 4; off += 2) begin
            access(lsu_pkg::OP_LH, w, 32'(off), 32'h0);
            access(lsu_pkg::OP_LHU, w, 32'(off), 32'h0);
            access(lsu_pkg::OP_SH, w, 32'(off), rand_bits(32));
        end
        access(lsu_pkg::OP_LW, w, 32'h0, 32'h0);  // word must be as first stored
        report_test("misaligned faults", e0);
    endtask

    task automatic latency_test();
        int          e0;
        logic [31:0] r;
        logic [31:0] w;
        e0 = errors;
        r  = rand_bits(30);
        w  = {r[29:0], 2'b00};
        access(lsu_pkg::OP_SW, w, 32'h0, rand_bits(32));  // aligned, four cycles
        access(lsu_pkg::OP_SH, w, 32'h1, rand_bits(32));  // fault, one cycle
        report_test("done latency", e0);
    endtask

    task automatic busy_strobe_test();
        int                e0;
        int                dones;
        logic [31:0]       r;
        logic [31:0]       w;
        logic [31:0]       d1;
        lsu_pkg::lsu_req_t first;
        e0          = errors;
        r           = rand_bits(30);
        w           = {r[29:0], 2'b00};
        d1          = rand_bits(32);
        first.op    = lsu_pkg::OP_SW;
        first.base  = w;
        first.offset = 32'h0;
        first.wdata = d1;
        @(negedge clk);
        req_valid = 1'b1;
        req       = first;
        @(negedge clk);
        req_valid = 1'b0;
        @(negedge clk);
        check("busy_o", 32'(busy), 32'h1);
        req_valid  = 1'b1;  // second store to the same word, should be dropped
        req.wdata  = ~d1;
        @(negedge clk);
        req_valid = 1'b0;
        dones     = 0;
        for (int i = 0; i < 10; i++) begin
            if (done) dones++;
            @(negedge clk);
        end
        check("done_o pulses", dones, 32'd1);
        ref_store(lsu_pkg::OP_SW, w, d1);
        access(lsu_pkg::OP_LW, w, 32'h0, 32'h0);
        report_test("strobe while busy", e0);
    endtask

    initial begin
        reset     = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        repeat (3) @(negedge clk);  // three rising edges in reset
        reset = 1'b0;
        word_roundtrip_test();
        subword_store_test();
        extension_test();
        misaligned_test();
        latency_test();
        busy_strobe_test();
        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
hdl/lsu_pkg.sv
hdl/agu.sv
hdl/wait_timer.sv
hdl/data_ram.sv
hdl/load_align.sv
hdl/lsu_ctrl.sv
hdl/lsu_top.sv
dv/lsu_tb.sv

// File: hdl/agu.sv
// purely combinational; the mask keeps a legal shape even for misaligned stores, so the write must be gated by the misaligned flag
`default_nettype none

module agu (
    input  wire lsu_pkg::lsu_req_t cur_req_i,  // request held by the controller
    output lsu_pkg::agu_res_t      res_o       // address, lanes and alignment verdict
);

    logic [31:0] addr;      // effective address
    logic [1:0]  byte_off;  // position inside the addressed word
    logic [4:0]  hw_shift;  // bit shift for a halfword lane
    logic [4:0]  b_shift;   // bit shift for a byte lane

    assign addr     = cur_req_i.base + cur_req_i.offset;  // offsets may be negative, plain add wraps
    assign byte_off = addr[1:0];
    assign b_shift  = {byte_off, 3'b000};                 // byte lane 0..3 times eight
    assign hw_shift = {byte_off[1], 4'b0000};             // halfword sits in the low or high half

    always_comb begin
        res_o      = '0;  // loads leave mask and data at zero
        res_o.addr = addr;
        case (cur_req_i.op)
            lsu_pkg::OP_LB, lsu_pkg::OP_LBU: begin
                res_o.is_load = 1'b1;  // a byte is never misaligned
            end
            lsu_pkg::OP_LH, lsu_pkg::OP_LHU: begin
                res_o.is_load    = 1'b1;
                res_o.misaligned = byte_off[0];  // halfwords need an even address
            end
            lsu_pkg::OP_LW: begin
                res_o.is_load    = 1'b1;
                res_o.misaligned = |byte_off;  // words need a multiple of four
            end
            lsu_pkg::OP_SB: begin
                res_o.is_store = 1'b1;
                res_o.wmask    = 4'b0001 << byte_off;                     // one lane
                res_o.wdata    = {24'h0, cur_req_i.wdata[7:0]} << b_shift;
            end
            lsu_pkg::OP_SH: begin
                res_o.is_store   = 1'b1;
                res_o.misaligned = byte_off[0];
                res_o.wmask      = 4'b0011 << {byte_off[1], 1'b0};        // low or high pair
                res_o.wdata      = {16'h0, cur_req_i.wdata[15:0]} << hw_shift;
            end
            lsu_pkg::OP_SW: begin
                res_o.is_store   = 1'b1;
                res_o.misaligned = |byte_off;
                res_o.wmask      = 4'b1111;  // whole word, no shift
                res_o.wdata      = cur_req_i.wdata;
            end
            default: begin
                res_o = '0;  // unreachable with a full enum, keeps the output defined
            end
        endcase
    end

    // a store must present a byte, an aligned halfword pair or the full word to the RAM
    always_comb begin
        if (res_o.is_store) begin
            a_legal_mask: assert final (res_o.wmask inside {
                4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100, 4'b1111
            });
        end
    end

endmodule

`default_nettype wire

// File: hdl/data_ram.sv
// contents are undefined after power up and there is no reset; a write also returns the old word on rdata_o
`default_nettype none

module data_ram (
    input  wire                        clk_i,
    input  wire                        en_i,     // access this cycle
    input  wire                        we_i,     // write when enabled
    input  wire [lsu_pkg::DMEM_AW-1:0] addr_i,   // word index
    input  wire [3:0]                  wmask_i,  // byte lanes to update
    input  wire [31:0]                 wdata_i,  // lane-aligned store data
    output logic [31:0]                rdata_o   // registered read word
);

    logic [31:0] mem_q [lsu_pkg::DMEM_WORDS];

    // write side updates only the enabled lanes of the addressed word
    always_ff @(posedge clk_i) begin
        if (en_i && we_i) begin
            for (int b = 0; b < 4; b++) begin
                if (wmask_i[b]) begin
                    mem_q[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
    end

    // read side registers the full word on every enabled cycle
    always_ff @(posedge clk_i) begin
        if (en_i) begin
            rdata_o <= mem_q[addr_i];  // read before write for the same edge
        end
    end

endmodule

`default_nettype wire

// File: hdl/load_align.sv
// combinational; alignment is checked upstream, and store opcodes give zero here
`default_nettype none

module load_align (
    input  wire lsu_pkg::mem_op_e op_i,        // load flavour of the held request
    input  wire [1:0]             byte_off_i,  // low address bits
    input  wire [31:0]            word_i,      // raw RAM word
    output logic [31:0]           data_o       // extended result
);

    logic [31:0] shifted;  // addressed byte or halfword moved to bit 0

    assign shifted = word_i >> {byte_off_i, 3'b000};

    always_comb begin
        case (op_i)
            lsu_pkg::OP_LB: begin
                data_o = {{24{shifted[7]}}, shifted[7:0]};    // sign from bit 7
            end
            lsu_pkg::OP_LBU: begin
                data_o = {24'h0, shifted[7:0]};
            end
            lsu_pkg::OP_LH: begin
                data_o = {{16{shifted[15]}}, shifted[15:0]};  // sign from bit 15
            end
            lsu_pkg::OP_LHU: begin
                data_o = {16'h0, shifted[15:0]};
            end
            lsu_pkg::OP_LW: begin
                data_o = word_i;  // word passes through untouched
            end
            default: begin
                data_o = 32'h0;   // stores carry no load data
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/lsu_ctrl.sv
// one request in flight; strobes while busy are dropped and rsp_o is only meaningful while done_o is high
`default_nettype none

module lsu_ctrl (
    input  wire                    clk_i,
    input  wire                    reset_i,
    input  wire                    req_valid_i,  // one-cycle request strobe
    input  wire lsu_pkg::lsu_req_t req_i,
    input  wire lsu_pkg::agu_res_t agu_res_i,    // derived from cur_req_o
    input  wire                    expired_i,    // wait states are over
    input  wire [31:0]             load_data_i,  // aligned and extended RAM word
    output lsu_pkg::lsu_req_t      cur_req_o,    // request being worked on
    output logic                   timer_load_o,
    output logic                   ram_en_o,
    output logic                   ram_we_o,
    output logic                   busy_o,
    output logic                   done_o,
    output lsu_pkg::lsu_rsp_t      rsp_o
);

    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,  // waiting for a strobe
        ST_WAIT   = 2'd1,  // memory wait states, or the fault decision
        ST_ACCESS = 2'd2,  // RAM enabled for exactly one edge
        ST_RESP   = 2'd3   // read word is on the RAM output
    } state_e;

    state_e            state_q;
    logic              done_q;  // registered completion pulse
    lsu_pkg::lsu_req_t req_q;   // captured request
    lsu_pkg::lsu_rsp_t rsp_q;   // captured response
    logic              accept;

    // done_q still counts as busy so busy_o falls one cycle after the pulse
    assign busy_o       = (state_q != ST_IDLE) || done_q;
    assign accept       = req_valid_i && !busy_o;
    assign timer_load_o = accept;                       // timer starts on the accepting edge
    assign ram_en_o     = (state_q == ST_ACCESS);
    assign ram_we_o     = ram_en_o && agu_res_i.is_store;
    assign cur_req_o    = req_q;
    assign done_o       = done_q;
    assign rsp_o        = rsp_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= ST_IDLE;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;  // default keeps done a single pulse
            case (state_q)
                ST_IDLE: begin
                    if (accept) state_q <= ST_WAIT;
                end
                ST_WAIT: begin
                    if (agu_res_i.misaligned) begin
                        state_q <= ST_IDLE;  // fault finishes right away
                        done_q  <= 1'b1;
                    end else if (expired_i) begin
                        state_q <= ST_ACCESS;
                    end
                end
                ST_ACCESS: state_q <= ST_RESP;  // RAM latches write or read here
                ST_RESP: begin
                    state_q <= ST_IDLE;
                    done_q  <= 1'b1;
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) req_q <= req_i;  // held steady until the next accept
        if ((state_q == ST_WAIT) && agu_res_i.misaligned) begin
            rsp_q.rdata <= '0;
            rsp_q.fault <= 1'b1;
        end else if (state_q == ST_RESP) begin
            rsp_q.rdata <= agu_res_i.is_load ? load_data_i : 32'h0;  // stores report zero
            rsp_q.fault <= 1'b0;
        end
    end

    a_done_pulse: assert property (@(posedge clk_i) disable iff (reset_i)
        done_o |=> !done_o);

    // the RAM is only touched once the timer loaded at accept has run out
    a_ram_en_window: assert property (@(posedge clk_i) disable iff (reset_i)
        ram_en_o |-> (state_q == ST_ACCESS) && !agu_res_i.misaligned
                     && $past(timer_load_o, lsu_pkg::MEM_WAIT_CYCLES + 1));

endmodule

`default_nettype wire

// File: hdl/lsu_pkg.sv
// shared types and sizes for the load/store unit; MEM_WAIT_CYCLES must fit in TIMER_W bits and be at least 1
`default_nettype none

package lsu_pkg;

    // memory timing and geometry
    localparam int unsigned MEM_WAIT_CYCLES = 2;   // wait states spent before the RAM access cycle
    localparam int unsigned DMEM_WORDS      = 64;  // RAM depth in 32-bit words
    localparam int unsigned DMEM_AW         = 6;   // word index width, so addresses wrap every 256 bytes
    localparam int unsigned TIMER_W         = 2;   // wait timer counter width

    // value loaded into the wait timer so it reaches zero after MEM_WAIT_CYCLES cycles
    localparam logic [TIMER_W-1:0] TIMER_RELOAD = TIMER_W'(MEM_WAIT_CYCLES - 1);

    // access type of one request, sequentially encoded rather than by funct3
    typedef enum logic [2:0] {
        OP_LB  = 3'd0,  // signed byte load
        OP_LH  = 3'd1,  // signed halfword load
        OP_LW  = 3'd2,  // word load
        OP_LBU = 3'd3,  // unsigned byte load
        OP_LHU = 3'd4,  // unsigned halfword load
        OP_SB  = 3'd5,  // byte store
        OP_SH  = 3'd6,  // halfword store
        OP_SW  = 3'd7   // word store
    } mem_op_e;

    // one memory request as handed over by the core
    typedef struct packed {
        mem_op_e     op;      // what kind of access this is
        logic [31:0] base;    // rs1 value
        logic [31:0] offset;  // immediate, already sign extended by the decoder
        logic [31:0] wdata;   // rs2 value, only the low bytes matter for sb and sh
    } lsu_req_t;

    // everything the address generation unit derives from a request
    typedef struct packed {
        logic [31:0] addr;        // effective byte address
        logic [3:0]  wmask;       // byte lanes to write, zero for loads
        logic [31:0] wdata;       // store data moved onto its lanes, zero for loads
        logic        is_load;     // set for the five load flavours
        logic        is_store;    // set for sb, sh and sw
        logic        misaligned;  // halfword or word access not on its natural boundary
    } agu_res_t;

    // completion record returned with the done pulse
    typedef struct packed {
        logic [31:0] rdata;  // extended load result, zero for stores and faults
        logic        fault;  // the access was misaligned and never reached the RAM
    } lsu_rsp_t;

endpackage

`default_nettype wire

// File: hdl/lsu_top.sv
// addresses wrap onto the 64-word RAM, done_o comes MEM_WAIT_CYCLES plus 2 cycles after accept, or 1 cycle on a fault
`default_nettype none

module lsu_top (
    input  wire                    clk_i,
    input  wire                    reset_i,
    input  wire                    req_valid_i,  // one-cycle request strobe
    input  wire lsu_pkg::lsu_req_t req_i,
    output logic                   busy_o,       // high from accept until after done
    output logic                   done_o,       // one-cycle completion pulse
    output lsu_pkg::lsu_rsp_t      rsp_o         // valid with done_o only
);

    lsu_pkg::lsu_req_t cur_req;     // request held by the controller
    lsu_pkg::agu_res_t agu_res;     // address and lanes for cur_req
    logic              timer_load;
    logic              expired;
    logic              ram_en;
    logic              ram_we;
    logic [31:0]       ram_rdata;   // registered RAM word
    logic [31:0]       load_data;   // aligned and extended load value

    lsu_ctrl u_ctrl (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .req_valid_i  (req_valid_i),
        .req_i        (req_i),
        .agu_res_i    (agu_res),
        .expired_i    (expired),
        .load_data_i  (load_data),
        .cur_req_o    (cur_req),
        .timer_load_o (timer_load),
        .ram_en_o     (ram_en),
        .ram_we_o     (ram_we),
        .busy_o       (busy_o),
        .done_o       (done_o),
        .rsp_o        (rsp_o)
    );

    agu u_agu (
        .cur_req_i (cur_req),
        .res_o     (agu_res)
    );

    wait_timer u_timer (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .load_i    (timer_load),
        .expired_o (expired)
    );

    data_ram u_ram (
        .clk_i   (clk_i),
        .en_i    (ram_en),
        .we_i    (ram_we),
        .addr_i  (agu_res.addr[lsu_pkg::DMEM_AW+1:2]),  // word index drops the byte offset
        .wmask_i (agu_res.wmask),
        .wdata_i (agu_res.wdata),
        .rdata_o (ram_rdata)
    );

    load_align u_align (
        .op_i       (cur_req.op),
        .byte_off_i (agu_res.addr[1:0]),
        .word_i     (ram_rdata),
        .data_o     (load_data)
    );

endmodule

`default_nettype wire

// File: hdl/wait_timer.sv
// counts from TIMER_RELOAD down to zero and holds there; expired_o is also high while idle, so sample it only after a load
`default_nettype none

module wait_timer (
    input  wire  clk_i,
    input  wire  reset_i,
    input  wire  load_i,     // restart the wait
    output logic expired_o   // wait states are over
);

    logic [lsu_pkg::TIMER_W-1:0] cnt_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            cnt_q <= '0;
        end else if (load_i) begin
            cnt_q <= lsu_pkg::TIMER_RELOAD;  // load wins over counting
        end else if (cnt_q != '0) begin
            cnt_q <= cnt_q - 1'b1;           // stop at zero
        end
    end

    assign expired_o = (cnt_q == '0) && !load_i;  // a load in the same cycle is not yet expired

    // a wrap below zero would leave the counter above its reload value
    a_no_wrap: assert property (@(posedge clk_i) disable iff (reset_i)
        cnt_q <= lsu_pkg::TIMER_RELOAD);

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it.
# Exit status is 0 only when the simulation prints the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f files.f \
    --top-module lsu_tb \
    --Mdir obj_dir \
    -o lsu_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/lsu_sim)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx 'Result: PASSED'; then
    exit 0
else
    exit 1
fi
